// File: src/seed_pkg.sv
// ****************************************
// shared widths and types for the seed finder
// all read-position arithmetic wraps modulo 32
// ****************************************

package seed_pkg;

    localparam int READ_LEN    = 16;
    localparam int POS_W       = 5;
    localparam int KLS_W       = 8;
    localparam int OCC_DEPTH   = 64;
    localparam int OCC_AW      = 6;
    localparam int QUEUE_DEPTH = 16;

    // j+1 at this value means the read is exhausted
    localparam logic [POS_W-1:0] READ_END = POS_W'(READ_LEN);

    // A C G T as 0..3, complement is 3-b
    typedef logic [1:0] sym_t;

    typedef sym_t [READ_LEN-1:0] read_t;

    typedef struct packed {
        logic [KLS_W-1:0] k;        // start in forward index
        logic [KLS_W-1:0] l;        // start in reverse index
        logic [KLS_W-1:0] s;        // interval size
    } interval_t;

    // match covers read positions i..j
    typedef struct packed {
        interval_t        iv;
        logic [POS_W-1:0] i;
        logic [POS_W-1:0] j;
    } work_item_t;

    typedef logic [3:0][KLS_W-1:0] occ_row_t;  // one count per base

    typedef struct packed {
        logic [OCC_AW-1:0] addr;
        occ_row_t          row;
    } occ_load_t;

    typedef struct packed {
        logic [3:0][KLS_W-1:0] c;     // cumulative counts per base
        logic [KLS_W-1:0]      primary;
        logic [KLS_W-1:0]      bwt_len;
        logic [POS_W-1:0]      min_len;
        logic [KLS_W-1:0]      min_intv;
    } seed_cfg_t;

endpackage

// File: src/occ_table.sv
// ****************************************
// rows are written only through the load port
// read data arrives one cycle after the address
// ****************************************
`timescale 1ns/1ns

module occ_table (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          load_valid,
    input  seed_pkg::occ_load_t           load,
    input  logic [seed_pkg::OCC_AW-1:0]   addr_a,
    input  logic [seed_pkg::OCC_AW-1:0]   addr_b,
    output seed_pkg::occ_row_t            row_a,
    output seed_pkg::occ_row_t            row_b
);

    seed_pkg::occ_row_t mem [seed_pkg::OCC_DEPTH];

    // load port
    always_ff @(posedge clk) begin
        if (load_valid) begin
            mem[load.addr] <= load.row;
        end
    end

    // both read ports registered, row at k and row at k+s
    always_ff @(posedge clk) begin
        if (rst) begin
            row_a <= '0;
            row_b <= '0;
        end else begin
            row_a <= mem[addr_a];
            row_b <= mem[addr_b];
        end
    end

endmodule

// File: src/interval_extend.sv
// ****************************************
// fixed 2-cycle extension, one in flight at a time
// k+s must stay inside the loaded table rows
// ****************************************
`timescale 1ns/1ns

module interval_extend (
    input  logic                  clk,
    input  logic                  rst,
    input  seed_pkg::seed_cfg_t   cfg,
    input  logic                  start,
    input  logic                  fwd,
    input  seed_pkg::sym_t        sym,
    input  seed_pkg::interval_t   iv_in,
    output logic                  done,
    output seed_pkg::interval_t   iv_out,
    input  logic                  load_valid,
    input  seed_pkg::occ_load_t   load
);

    seed_pkg::interval_t iv_sw;        // input with k/l swapped for forward
    seed_pkg::interval_t iv_q;
    seed_pkg::sym_t      a_q;          // effective base
    logic                fwd_q;
    logic                busy_q;

    logic [seed_pkg::KLS_W-1:0]  ks_sum;
    logic [seed_pkg::OCC_AW-1:0] addr_k;
    logic [seed_pkg::OCC_AW-1:0] addr_ks;
    seed_pkg::occ_row_t          row_k;
    seed_pkg::occ_row_t          row_ks;

    logic [3:0][seed_pkg::KLS_W-1:0] k_new;
    logic [3:0][seed_pkg::KLS_W-1:0] l_new;
    logic [3:0][seed_pkg::KLS_W-1:0] s_new;
    logic [seed_pkg::KLS_W:0]        k_end;  // one extra bit, no wrap
    logic                            sentinel;

    // forward extension runs as backward on the swapped interval
    always_comb begin
        iv_sw = iv_in;
        if (fwd) begin
            iv_sw.k = iv_in.l;
            iv_sw.l = iv_in.k;
        end
    end

    assign ks_sum  = iv_sw.k + iv_sw.s;
    assign addr_k  = iv_sw.k[seed_pkg::OCC_AW-1:0];
    assign addr_ks = ks_sum[seed_pkg::OCC_AW-1:0];

    occ_table u_occ (
        .clk        (clk),
        .rst        (rst),
        .load_valid (load_valid),
        .load       (load),
        .addr_a     (addr_k),
        .addr_b     (addr_ks),
        .row_a      (row_k),
        .row_b      (row_ks)
    );

    always_ff @(posedge clk) begin
        if (start) begin
            iv_q  <= iv_sw;
            a_q   <= fwd ? ~sym : sym;   // complement base going forward
            fwd_q <= fwd;
        end
    end

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            k_new[b] = cfg.c[b] + row_k[b] + 1'b1;
            s_new[b] = row_ks[b] - row_k[b];
        end
        k_end    = {1'b0, iv_q.k} + {1'b0, iv_q.s};
        sentinel = (iv_q.k <= cfg.primary) && ({1'b0, cfg.primary} < k_end);
        l_new[3] = iv_q.l + {{(seed_pkg::KLS_W-1){1'b0}}, sentinel};
        // reverse starts accumulate from T down to A
        for (int b = 2; b >= 0; b--) begin
            l_new[b] = l_new[b+1] + s_new[b+1];
        end
    end

    always_ff @(posedge clk) begin
        if (busy_q) begin
            iv_out.s <= s_new[a_q];
            iv_out.k <= fwd_q ? l_new[a_q] : k_new[a_q];  // swap back
            iv_out.l <= fwd_q ? k_new[a_q] : l_new[a_q];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            done   <= 1'b0;
        end else begin
            busy_q <= start;
            done   <= busy_q;
        end
    end

endmodule

// File: src/work_queue.sv
// ****************************************
// no full flag, caller must not exceed depth
// dout is valid the cycle after pop
// ****************************************
`timescale 1ns/1ns

module work_queue (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push,
    input  seed_pkg::work_item_t  din,
    input  logic                  pop,
    output seed_pkg::work_item_t  dout,
    output logic                  empty
);

    seed_pkg::work_item_t mem [seed_pkg::QUEUE_DEPTH];

    logic [$clog2(seed_pkg::QUEUE_DEPTH)-1:0] wr_ptr;
    logic [$clog2(seed_pkg::QUEUE_DEPTH)-1:0] rd_ptr;
    logic [$clog2(seed_pkg::QUEUE_DEPTH):0]   count;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
        if (pop) begin
            dout <= mem[rd_ptr];   // registered head
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign empty = (count == '0);

endmodule

// File: src/seed_control.sv
// ****************************************
// job_pos must be below READ_LEN
// a stalled output stream halts the whole search
// ****************************************
`timescale 1ns/1ns

module seed_control (
    input  logic                          clk,
    input  logic                          rst,
    input  seed_pkg::seed_cfg_t           cfg,
    input  logic                          job_valid,
    output logic                          job_ready,
    input  seed_pkg::read_t               job_read,
    input  logic [seed_pkg::POS_W-1:0]    job_pos,
    output logic                          ext_start,
    output logic                          ext_fwd,
    output seed_pkg::sym_t                ext_sym,
    output seed_pkg::interval_t           ext_in,
    input  logic                          ext_done,
    input  seed_pkg::interval_t           ext_out,
    output logic                          q_push,
    output seed_pkg::work_item_t          q_din,
    output logic                          q_pop,
    input  seed_pkg::work_item_t          q_dout,
    input  logic                          q_empty,
    output logic                          seed_valid,
    input  logic                          seed_ready,
    output seed_pkg::work_item_t          seed,
    output logic [seed_pkg::POS_W-1:0]    next_pos,
    output logic                          done
);

    localparam int IDX_W = $clog2(seed_pkg::READ_LEN);

    typedef enum logic [3:0] {
        S_IDLE,
        S_FWD_EXT,
        S_FWD_WAIT,
        S_FWD_CHK,
        S_POP,
        S_LOAD,
        S_BWD_EXT,
        S_BWD_WAIT,
        S_BWD_CHK,
        S_EMIT
    } state_t;

    state_t state;

    seed_pkg::read_t             read_q;
    seed_pkg::work_item_t        cur;       // old item
    seed_pkg::interval_t         new_iv;    // result of the last step
    logic [seed_pkg::POS_W-1:0]  end_pos;

    logic [seed_pkg::POS_W-1:0]  j_nxt;
    logic [seed_pkg::POS_W-1:0]  i_prv;
    logic [seed_pkg::POS_W-1:0]  match_len;
    logic                        s_changed;
    logic                        keep_going;
    logic                        want_push;
    logic                        want_emit;
    logic                        bwd_step;

    assign j_nxt     = cur.j + 1'b1;
    assign i_prv     = cur.i - 1'b1;
    assign match_len = cur.j - cur.i + 1'b1;

    assign s_changed  = (new_iv.s != cur.iv.s);
    assign keep_going = (new_iv.s > cfg.min_intv);
    assign want_push  = s_changed && (cur.iv.s != cfg.bwt_len);
    assign want_emit  = s_changed && (match_len >= cfg.min_len);

    // leaving a backward check, either directly or after the emit
    assign bwd_step = (state == S_BWD_CHK && !want_emit)
                   || (state == S_EMIT && seed_ready);

    // extension request, shortcuts skip the unit
    assign ext_start = (state == S_FWD_EXT && j_nxt != seed_pkg::READ_END)
                    || (state == S_BWD_EXT && cur.i != '0);
    assign ext_fwd   = (state == S_FWD_EXT);
    assign ext_sym   = ext_fwd ? read_q[j_nxt[IDX_W-1:0]] : read_q[i_prv[IDX_W-1:0]];
    assign ext_in    = cur.iv;

    assign q_push = (state == S_FWD_CHK) && want_push;
    assign q_din  = cur;
    assign q_pop  = (state == S_POP) && !q_empty;

    assign job_ready  = (state == S_IDLE);
    assign seed_valid = (state == S_EMIT);
    assign seed       = cur;     // held while in S_EMIT

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= S_IDLE;
            done     <= 1'b0;
            next_pos <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (job_valid) state <= S_FWD_EXT;
                end
                S_FWD_EXT: begin
                    state <= ext_start ? S_FWD_WAIT : S_FWD_CHK;
                end
                S_FWD_WAIT: begin
                    if (ext_done) state <= S_FWD_CHK;
                end
                S_FWD_CHK: begin
                    state <= keep_going ? S_FWD_EXT : S_POP;
                end
                S_POP: begin
                    if (q_empty) begin
                        state    <= S_IDLE;
                        done     <= 1'b1;
                        next_pos <= end_pos;
                    end else begin
                        state <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    state <= S_BWD_EXT;    // q_dout valid now
                end
                S_BWD_EXT: begin
                    state <= ext_start ? S_BWD_WAIT : S_BWD_CHK;
                end
                S_BWD_WAIT: begin
                    if (ext_done) state <= S_BWD_CHK;
                end
                S_BWD_CHK, S_EMIT: begin
                    if (state == S_BWD_CHK && want_emit) begin
                        state <= S_EMIT;
                    end else if (bwd_step) begin
                        state <= keep_going ? S_BWD_EXT : S_POP;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // working registers
    always_ff @(posedge clk) begin
        case (state)
            S_IDLE: begin
                if (job_valid) begin
                    read_q   <= job_read;
                    cur.iv.k <= '0;
                    cur.iv.l <= '0;
                    cur.iv.s <= cfg.bwt_len;   // whole index
                    cur.i    <= job_pos;
                    cur.j    <= job_pos - 1'b1;
                end
            end
            S_FWD_EXT, S_BWD_EXT: begin
                if (!ext_start) new_iv <= '0;  // read end or i at 0
            end
            S_FWD_WAIT, S_BWD_WAIT: begin
                if (ext_done) new_iv <= ext_out;
            end
            S_FWD_CHK: begin
                if (keep_going) begin
                    cur.iv <= new_iv;
                    cur.j  <= j_nxt;
                end else begin
                    end_pos <= j_nxt;
                end
            end
            S_LOAD: begin
                cur <= q_dout;
            end
            S_BWD_CHK, S_EMIT: begin
                if (bwd_step && keep_going) begin
                    cur.iv <= new_iv;
                    cur.i  <= i_prv;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// File: src/seed_seek_top.sv
// ****************************************
// load table rows and config before the first job
// ****************************************
`timescale 1ns/1ns

module seed_seek_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          occ_load_valid,
    input  seed_pkg::occ_load_t           occ_load,
    input  logic                          cfg_valid,
    input  seed_pkg::seed_cfg_t           cfg,
    input  logic                          job_valid,
    output logic                          job_ready,
    input  seed_pkg::read_t               job_read,
    input  logic [seed_pkg::POS_W-1:0]    job_pos,
    output logic                          seed_valid,
    input  logic                          seed_ready,
    output seed_pkg::work_item_t          seed,
    output logic [seed_pkg::POS_W-1:0]    next_pos,
    output logic                          done
);

    seed_pkg::seed_cfg_t  cfg_q;

    logic                 ext_start;
    logic                 ext_fwd;
    logic                 ext_done;
    seed_pkg::sym_t       ext_sym;
    seed_pkg::interval_t  ext_in;
    seed_pkg::interval_t  ext_out;

    logic                 q_push;
    logic                 q_pop;
    logic                 q_empty;
    seed_pkg::work_item_t q_din;
    seed_pkg::work_item_t q_dout;

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_q <= '0;
        end else if (cfg_valid) begin
            cfg_q <= cfg;          // single-cycle config load
        end
    end

    seed_control u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg_q),
        .job_valid  (job_valid),
        .job_ready  (job_ready),
        .job_read   (job_read),
        .job_pos    (job_pos),
        .ext_start  (ext_start),
        .ext_fwd    (ext_fwd),
        .ext_sym    (ext_sym),
        .ext_in     (ext_in),
        .ext_done   (ext_done),
        .ext_out    (ext_out),
        .q_push     (q_push),
        .q_din      (q_din),
        .q_pop      (q_pop),
        .q_dout     (q_dout),
        .q_empty    (q_empty),
        .seed_valid (seed_valid),
        .seed_ready (seed_ready),
        .seed       (seed),
        .next_pos   (next_pos),
        .done       (done)
    );

    interval_extend u_ext (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg_q),
        .start      (ext_start),
        .fwd        (ext_fwd),
        .sym        (ext_sym),
        .iv_in      (ext_in),
        .done       (ext_done),
        .iv_out     (ext_out),
        .load_valid (occ_load_valid),
        .load       (occ_load)
    );

    work_queue u_queue (
        .clk   (clk),
        .rst   (rst),
        .push  (q_push),
        .din   (q_din),
        .pop   (q_pop),
        .dout  (q_dout),
        .empty (q_empty)
    );

endmodule

// File: sim/tb_seed_seek.sv
// ****************************************
// directed tests against a model of the search rules
// 40-symbol random BWT from a fixed-seed LCG
// ****************************************
`timescale 1ns/1ns

module tb_seed_seek;

    localparam int CLK_PERIOD = 40;
    localparam int BWT_LEN    = 40;
    localparam int NUM_JOBS   = 10;
    localparam int TIMEOUT_CYCLES = NUM_JOBS * 200 + 2 * seed_pkg::OCC_DEPTH + 100;

    logic                          clk;
    logic                          rst;
    logic                          occ_load_valid;
    seed_pkg::occ_load_t           occ_load;
    logic                          cfg_valid;
    seed_pkg::seed_cfg_t           cfg;
    logic                          job_valid;
    logic                          job_ready;
    seed_pkg::read_t               job_read;
    logic [seed_pkg::POS_W-1:0]    job_pos;
    logic                          seed_valid;
    logic                          seed_ready;
    seed_pkg::work_item_t          seed;
    logic [seed_pkg::POS_W-1:0]    next_pos;
    logic                          done;

    logic [31:0]          lcg_state = 32'h389e8c88;
    seed_pkg::sym_t       bwt [BWT_LEN];
    seed_pkg::occ_row_t   occ_rows [seed_pkg::OCC_DEPTH];
    seed_pkg::seed_cfg_t  cfg_cur;                 // model copy of the config
    seed_pkg::work_item_t expected [$];

    seed_seek_top uut (
        .clk            (clk),
        .rst            (rst),
        .occ_load_valid (occ_load_valid),
        .occ_load       (occ_load),
        .cfg_valid      (cfg_valid),
        .cfg            (cfg),
        .job_valid      (job_valid),
        .job_ready      (job_ready),
        .job_read       (job_read),
        .job_pos        (job_pos),
        .seed_valid     (seed_valid),
        .seed_ready     (seed_ready),
        .seed           (seed),
        .next_pos       (next_pos),
        .done           (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: the DUT did not finish all jobs in time");
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic compare_seed(input string name, input seed_pkg::work_item_t exp,
                                input seed_pkg::work_item_t act);
        if (exp !== act) begin
            stop_with_error($sformatf("Fail %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic compare_pos(input string name, input logic [seed_pkg::POS_W-1:0] exp,
                               input logic [seed_pkg::POS_W-1:0] act);
        if (exp !== act) begin
            stop_with_error($sformatf("Fail %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            stop_with_error($sformatf("Fail %s expected %b actual %b", name, exp, act));
        end
    endtask

    // one backward step, forward runs on the swapped interval with the complement
    function automatic seed_pkg::interval_t extend_ref(input seed_pkg::interval_t iv,
                                                       input seed_pkg::sym_t a, input bit fwd);
        seed_pkg::interval_t res;
        logic [7:0]          k;
        logic [7:0]          l;
        logic [7:0]          ks;
        logic [3:0][7:0]     kn;
        logic [3:0][7:0]     sn;
        logic [3:0][7:0]     ln;
        seed_pkg::sym_t      base;
        bit                  sent;
        k    = fwd ? iv.l : iv.k;
        l    = fwd ? iv.k : iv.l;
        ks   = k + iv.s;
        base = fwd ? 2'd3 - a : a;
        for (int b = 0; b < 4; b++) begin
            kn[b] = cfg_cur.c[b] + occ_rows[k[5:0]][b] + 8'd1;
            sn[b] = occ_rows[ks[5:0]][b] - occ_rows[k[5:0]][b];
        end
        sent  = (int'(k) <= int'(cfg_cur.primary))
             && (int'(cfg_cur.primary) < int'(k) + int'(iv.s));
        ln[3] = l + 8'(sent);
        ln[2] = ln[3] + sn[3];
        ln[1] = ln[2] + sn[2];
        ln[0] = ln[1] + sn[1];
        res.s = sn[base];
        res.k = fwd ? ln[base] : kn[base];
        res.l = fwd ? kn[base] : ln[base];
        return res;
    endfunction

    // fills the expected seed list for one job
    function automatic void search_ref(input seed_pkg::read_t rd, input logic [4:0] pos,
                                       output logic [4:0] np);
        seed_pkg::work_item_t cur;
        seed_pkg::work_item_t pend [$];
        seed_pkg::interval_t  nw;
        logic [4:0]           jn;
        logic [4:0]           ip;
        logic [4:0]           len;
        expected.delete();
        np     = pos;
        cur.iv = '{k: 8'd0, l: 8'd0, s: cfg_cur.bwt_len};
        cur.i  = pos;
        cur.j  = pos - 5'd1;
        for (int n = 0; n < 32; n++) begin
            jn = cur.j + 5'd1;
            nw = (jn == 5'd16) ? '0 : extend_ref(cur.iv, rd[jn[3:0]], 1'b1);
            if (nw.s != cur.iv.s && cur.iv.s != cfg_cur.bwt_len) pend.push_back(cur);
            if (nw.s > cfg_cur.min_intv) begin
                cur.iv = nw;
                cur.j  = jn;
            end else begin
                np = jn;
                break;
            end
        end
        while (pend.size() > 0) begin
            cur = pend.pop_front();
            for (int n = 0; n < 32; n++) begin
                ip  = cur.i - 5'd1;
                nw  = (cur.i == 5'd0) ? '0 : extend_ref(cur.iv, rd[ip[3:0]], 1'b0);
                len = cur.j - cur.i + 5'd1;
                if (nw.s != cur.iv.s && len >= cfg_cur.min_len) expected.push_back(cur);
                if (nw.s <= cfg_cur.min_intv) break;
                cur.iv = nw;
                cur.i  = ip;
            end
        end
    endfunction

    function automatic seed_pkg::read_t make_read();
        seed_pkg::read_t rd;
        logic [31:0]     r;
        for (int n = 0; n < seed_pkg::READ_LEN; n++) begin
            r     = lcg_next();
            rd[n] = r[17:16];
        end
        return rd;
    endfunction

    // random BWT, prefix counts per row, cumulative counts
    task automatic load_index();
        int          cnt [4];
        logic [31:0] r;
        cnt = '{0, 0, 0, 0};
        for (int p = 0; p < BWT_LEN; p++) begin
            r      = lcg_next();
            bwt[p] = r[19:18];
        end
        r = lcg_next();
        cfg_cur.primary = 8'(r % BWT_LEN);
        cfg_cur.bwt_len = 8'(BWT_LEN);
        for (int p = 0; p < seed_pkg::OCC_DEPTH; p++) begin
            for (int b = 0; b < 4; b++) occ_rows[p][b] = 8'(cnt[b]);
            if (p < BWT_LEN) cnt[bwt[p]]++;
            occ_load_valid <= 1'b1;
            occ_load       <= '{addr: 6'(p), row: occ_rows[p]};
            @(posedge clk);
        end
        occ_load_valid <= 1'b0;
        cfg_cur.c[0] = 8'd0;
        for (int b = 1; b < 4; b++) cfg_cur.c[b] = cfg_cur.c[b-1] + 8'(cnt[b-1]);
    endtask

    task automatic set_cfg(input logic [7:0] min_intv, input logic [4:0] min_len);
        cfg_cur.min_intv = min_intv;
        cfg_cur.min_len  = min_len;
        cfg       <= cfg_cur;
        cfg_valid <= 1'b1;
        @(posedge clk);
        cfg_valid <= 1'b0;
    endtask

    // holds job_valid until the edge that sees job_ready high
    task automatic start_job(input logic [4:0] pos, input seed_pkg::read_t rd);
        logic ready_seen;
        job_valid <= 1'b1;
        job_read  <= rd;
        job_pos   <= pos;
        do begin
            @(negedge clk);
            ready_seen = job_ready;
            @(posedge clk);
        end while (!ready_seen);
        job_valid <= 1'b0;
    endtask

    // follows the stream until done, checking order, stalls and job_ready
    task automatic collect_job(input string name, input bit rand_ready,
                               input logic [4:0] exp_np);
        seed_pkg::work_item_t held;
        logic [31:0]          r;
        bit                   stalled;
        bit                   fin;
        stalled = 1'b0;
        fin     = 1'b0;
        while (!fin) begin
            @(negedge clk);
            if (stalled) begin
                compare_bit({name, " valid held"}, 1'b1, seed_valid);
                compare_seed({name, " stalled seed"}, held, seed);
            end
            stalled = seed_valid && !seed_ready;
            held    = seed;
            if (seed_valid && seed_ready) begin
                if (expected.size() == 0) begin
                    stop_with_error({name, ": DUT sent a seed that the model does not expect"});
                end else begin
                    compare_seed(name, expected.pop_front(), seed);
                end
            end
            if (done) begin
                compare_bit({name, " job_ready"}, 1'b1, job_ready);  // idle again
                compare_pos({name, " next_pos"}, exp_np, next_pos);
                if (expected.size() != 0) begin
                    stop_with_error({name, ": DUT finished before sending all seeds"});
                end
                fin = 1'b1;
            end else begin
                compare_bit({name, " job_ready"}, 1'b0, job_ready);  // busy mid-job
            end
            r = lcg_next();
            @(posedge clk);
            seed_ready <= rand_ready ? r[20] : 1'b1;
        end
    endtask

    task automatic run_job(input string name, input logic [4:0] pos, input bit rand_ready);
        seed_pkg::read_t rd;
        logic [4:0]      np;
        rd = make_read();
        search_ref(rd, pos, np);
        start_job(pos, rd);
        collect_job(name, rand_ready, np);
    endtask

    task automatic test_idle();
        @(negedge clk);
        compare_bit("idle job_ready", 1'b1, job_ready);
        compare_bit("idle seed_valid", 1'b0, seed_valid);
        compare_bit("idle done", 1'b0, done);
        @(posedge clk);
    endtask

    task automatic test_thresholds();
        set_cfg(8'd2, 5'd1);
        run_job("min_intv 2", 5'd0, 1'b0);
        set_cfg(8'd0, 5'd3);
        run_job("min_len 3", 5'd2, 1'b0);
        set_cfg(8'd50, 5'd1);          // above bwt_len, nothing survives
        run_job("no seeds", 5'd5, 1'b0);
    endtask

    // second job waits on job_valid while the first one runs
    task automatic test_back_to_back();
        seed_pkg::read_t rd_a;
        seed_pkg::read_t rd_b;
        logic [4:0]      np_a;
        logic [4:0]      np_b;
        rd_a = make_read();
        rd_b = make_read();
        search_ref(rd_a, 5'd0, np_a);
        start_job(5'd0, rd_a);
        job_valid <= 1'b1;
        job_read  <= rd_b;
        job_pos   <= 5'd13;
        collect_job("back to back first", 1'b0, np_a);
        job_valid <= 1'b0;             // taken on the edge after done
        search_ref(rd_b, 5'd13, np_b);
        collect_job("back to back second", 1'b0, np_b);
    endtask

    initial begin
        rst            <= 1'b1;
        occ_load_valid <= 1'b0;
        occ_load       <= '0;
        cfg_valid      <= 1'b0;
        cfg            <= '0;
        job_valid      <= 1'b0;
        job_read       <= '0;
        job_pos        <= '0;
        seed_ready     <= 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        test_idle();
        load_index();
        set_cfg(8'd0, 5'd1);
        run_job("basic", 5'd0, 1'b0);
        test_thresholds();
        set_cfg(8'd0, 5'd1);
        run_job("backpressure a", 5'd0, 1'b1);
        run_job("backpressure b", 5'd4, 1'b1);
        run_job("read end 15", 5'd15, 1'b0);
        run_job("read end 14", 5'd14, 1'b0);
        test_back_to_back();
        $display("All checks passed");
        $finish;
    end

endmodule

// File: verilog.f
src/seed_pkg.sv
src/occ_table.sv
src/interval_extend.sv
src/work_queue.sv
src/seed_control.sv
src/seed_seek_top.sv
sim/tb_seed_seek.sv

// File: run.sh
#!/bin/sh
# compile and run the seed finder testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tb_seed_seek \
    -Mdir obj_dir -o tb_seed_seek
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/tb_seed_seek
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0
